//--- verilog/npc_consts.svh
`ifndef NPC_CONSTS_SVH
`define NPC_CONSTS_SVH

// memory geometry, 64-bit words
// bank select is addr[4:3], word index is addr[12:5]
`define NPC_BANKS 4
`define NPC_BANK_WORDS 256

// axi id width, same as the core's io_master ids
`define NPC_ID_W 4

// read data FIFO entries in the merger
`define NPC_RBUF_DEPTH 4

// byte offset inside one 64-bit beat
`define NPC_BEAT_SHIFT 3

`endif

//--- verilog/npc_axi_pkg.sv
`default_nettype none
`include "npc_consts.svh"

package npc_axi_pkg;

  typedef logic [`NPC_ID_W-1:0] id_t;
  typedef logic [$clog2(`NPC_BANKS)-1:0] bank_t;
  typedef logic [$clog2(`NPC_BANK_WORDS)-1:0] widx_t;
  typedef logic [$clog2(`NPC_RBUF_DEPTH+1)-1:0] room_t;

  // AW and AR carry the same fields
  typedef struct packed {
    logic [31:0] addr;
    id_t         id;
    logic [7:0]  len;
    logic [2:0]  size;
    logic [1:0]  burst;
  } axi_aw_t;

  typedef struct packed {
    logic [63:0] data;
    logic [7:0]  strb;
    logic        last;
  } axi_w_t;

  typedef struct packed {
    id_t        id;
    logic [1:0] resp;
  } axi_b_t;

  typedef struct packed {
    logic [63:0] data;
    id_t         id;
    logic [1:0]  resp;
    logic        last;
  } axi_r_t;

  typedef struct packed {
    logic        we;
    widx_t       widx;
    bank_t       bank;
    logic [63:0] data;
    logic [7:0]  strb;
    id_t         id;    // read tag
    logic        last;  // read tag
  } bank_req_t;

  typedef struct packed {
    logic        valid;
    logic [63:0] data;
  } bank_rsp_t;

endpackage

`default_nettype wire

//--- verilog/npc_ram_bank.sv
`default_nettype none
`include "npc_consts.svh"

module npc_ram_bank #(
  parameter int unsigned BANK_ID = 0
) (
  input  logic                   clock,
  input  logic                   rst_n,
  input  logic                   req_valid,
  input  npc_axi_pkg::bank_req_t req,
  output npc_axi_pkg::bank_rsp_t rsp
);

  localparam npc_axi_pkg::bank_t SEL = npc_axi_pkg::bank_t'(BANK_ID);

  logic [63:0] mem [`NPC_BANK_WORDS];
  logic [63:0] rd_data;
  logic        rd_valid;
  logic        hit;

  assign hit = req_valid && (req.bank == SEL);

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      rd_valid <= 1'b0;
    end else begin
      rd_valid <= hit && !req.we;  // one-cycle pulse per read
    end
  end

  always_ff @(posedge clock) begin
    if (hit && req.we) begin
      for (int i = 0; i < 8; i++) begin
        if (req.strb[i]) mem[req.widx][i*8 +: 8] <= req.data[i*8 +: 8];
      end
    end
    if (hit && !req.we) begin
      rd_data <= mem[req.widx];
    end
  end

  assign rsp.valid = rd_valid;
  assign rsp.data  = rd_data;

endmodule

`default_nettype wire

//--- verilog/npc_burst_ctrl.sv
`default_nettype none
`include "npc_consts.svh"

module npc_burst_ctrl (
  input  logic                   clock,
  input  logic                   rst_n,
  input  logic                   aw_valid,
  input  npc_axi_pkg::axi_aw_t   aw,
  output logic                   aw_ready,
  input  logic                   w_valid,
  input  npc_axi_pkg::axi_w_t    w,
  output logic                   w_ready,
  output logic                   b_valid,
  output npc_axi_pkg::axi_b_t    b,
  input  logic                   b_ready,
  input  logic                   ar_valid,
  input  npc_axi_pkg::axi_aw_t   ar,
  output logic                   ar_ready,
  output logic                   req_valid,
  output npc_axi_pkg::bank_req_t req,
  input  npc_axi_pkg::room_t     merge_room
);

  localparam int BANK_W = $clog2(`NPC_BANKS);
  localparam int WIDX_W = $clog2(`NPC_BANK_WORDS);
  localparam int ADDR_W = `NPC_BEAT_SHIFT + BANK_W + WIDX_W;  // 8 KiB space

  typedef enum logic [1:0] {
    S_IDLE,
    S_WR,
    S_RD
  } state_t;

  state_t                 state;
  state_t                 state_nxt;
  logic                   aw_ready_q;
  logic                   b_valid_q;
  logic [ADDR_W-1:0]      addr_q;
  npc_axi_pkg::id_t       id_q;
  logic [7:0]             cnt_q;     // beats left after the current one
  logic                   aw_fire;
  logic                   ar_fire;
  logic                   w_fire;
  logic                   b_fire;
  logic                   rd_issue;

  assign aw_ready = aw_ready_q;
  assign ar_ready = aw_ready_q && !aw_valid;  // writes win
  assign w_ready  = (state == S_WR) && !b_valid_q;
  assign b_valid  = b_valid_q;
  assign b.id     = id_q;
  assign b.resp   = 2'b00;

  assign aw_fire  = aw_valid && aw_ready;
  assign ar_fire  = ar_valid && ar_ready;
  assign w_fire   = w_valid && w_ready;
  assign b_fire   = b_valid_q && b_ready;
  // only issue with a free slot in the merger
  assign rd_issue = (state == S_RD) && (merge_room != '0);

  always_comb begin
    state_nxt = state;
    case (state)
      S_IDLE: begin
        if (aw_fire) begin
          state_nxt = S_WR;
        end else if (ar_fire) begin
          state_nxt = S_RD;
        end
      end
      S_WR: begin
        if (b_fire) begin
          state_nxt = S_IDLE;
        end
      end
      S_RD: begin
        if (rd_issue && cnt_q == 8'd0) begin
          state_nxt = S_IDLE;
        end
      end
      default: state_nxt = S_IDLE;
    endcase
  end

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      state      <= S_IDLE;
      aw_ready_q <= 1'b0;
      b_valid_q  <= 1'b0;
    end else begin
      state      <= state_nxt;
      aw_ready_q <= (state_nxt == S_IDLE);
      if (w_fire && w.last) begin
        b_valid_q <= 1'b1;
      end else if (b_fire) begin
        b_valid_q <= 1'b0;
      end
    end
  end

  // burst address and beat count, upper address bits dropped
  always_ff @(posedge clock) begin
    if (aw_fire) begin
      addr_q <= {aw.addr[ADDR_W-1:`NPC_BEAT_SHIFT], {`NPC_BEAT_SHIFT{1'b0}}};
      id_q   <= aw.id;
      cnt_q  <= aw.len;
    end else if (ar_fire) begin
      addr_q <= {ar.addr[ADDR_W-1:`NPC_BEAT_SHIFT], {`NPC_BEAT_SHIFT{1'b0}}};
      id_q   <= ar.id;
      cnt_q  <= ar.len;
    end else if (w_fire || rd_issue) begin
      addr_q <= addr_q + ADDR_W'(8);  // wraps at 8 KiB
      cnt_q  <= cnt_q - 8'd1;
    end
  end

  assign req_valid = w_fire || rd_issue;
  assign req.we    = (state == S_WR);
  assign req.bank  = addr_q[`NPC_BEAT_SHIFT +: BANK_W];
  assign req.widx  = addr_q[ADDR_W-1 -: WIDX_W];
  assign req.data  = w.data;
  assign req.strb  = w.strb;
  assign req.id    = id_q;
  assign req.last  = (state == S_WR) ? w.last : (cnt_q == 8'd0);

endmodule

`default_nettype wire

//--- verilog/npc_rdata_merge.sv
`default_nettype none
`include "npc_consts.svh"

module npc_rdata_merge (
  input  logic                                    clock,
  input  logic                                    rst_n,
  input  logic                                    req_valid,
  input  npc_axi_pkg::bank_req_t                  req,
  input  npc_axi_pkg::bank_rsp_t [`NPC_BANKS-1:0] rsp,
  output logic                                    r_valid,
  output npc_axi_pkg::axi_r_t                     r,
  input  logic                                    r_ready,
  output npc_axi_pkg::room_t                      merge_room
);

  localparam int PTR_W = $clog2(`NPC_RBUF_DEPTH);

  // tag of the read that the banks are serving this cycle
  logic                 tag_valid;
  npc_axi_pkg::bank_t   tag_bank;
  npc_axi_pkg::id_t     tag_id;
  logic                 tag_last;

  npc_axi_pkg::axi_r_t  fifo_mem [`NPC_RBUF_DEPTH];
  logic [PTR_W-1:0]     wr_ptr;
  logic [PTR_W-1:0]     rd_ptr;
  npc_axi_pkg::room_t   count;
  logic                 push;
  logic                 pop;

  assign push = tag_valid && rsp[tag_bank].valid;
  assign pop  = r_valid && r_ready;

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      tag_valid <= 1'b0;
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      count     <= '0;
    end else begin
      tag_valid <= req_valid && !req.we;
      if (push) wr_ptr <= wr_ptr + PTR_W'(1);
      if (pop) rd_ptr <= rd_ptr + PTR_W'(1);
      count <= count + npc_axi_pkg::room_t'(push) - npc_axi_pkg::room_t'(pop);
    end
  end

  always_ff @(posedge clock) begin
    tag_bank <= req.bank;
    tag_id   <= req.id;
    tag_last <= req.last;
    if (push) begin
      fifo_mem[wr_ptr] <= '{data: rsp[tag_bank].data, id: tag_id, resp: 2'b00,
                            last: tag_last};
    end
  end

  assign r_valid = (count != '0);
  assign r       = fifo_mem[rd_ptr];

  // free slots minus the beat still in the bank stage
  assign merge_room = npc_axi_pkg::room_t'(`NPC_RBUF_DEPTH) - count
                    - npc_axi_pkg::room_t'(tag_valid);

endmodule

`default_nettype wire

//--- verilog/npc_mem_top.sv
`default_nettype none
`include "npc_consts.svh"

module npc_mem_top (
  input  logic                 clock,
  input  logic                 rst_n,
  // write address
  input  logic                 aw_valid,
  output logic                 aw_ready,
  input  logic [31:0]          aw_addr,
  input  logic [`NPC_ID_W-1:0] aw_id,
  input  logic [7:0]           aw_len,
  input  logic [2:0]           aw_size,
  input  logic [1:0]           aw_burst,
  // write data
  input  logic                 w_valid,
  output logic                 w_ready,
  input  logic [63:0]          w_data,
  input  logic [7:0]           w_strb,
  input  logic                 w_last,
  // write response
  output logic                 b_valid,
  input  logic                 b_ready,
  output logic [1:0]           b_resp,
  output logic [`NPC_ID_W-1:0] b_id,
  // read address
  input  logic                 ar_valid,
  output logic                 ar_ready,
  input  logic [31:0]          ar_addr,
  input  logic [`NPC_ID_W-1:0] ar_id,
  input  logic [7:0]           ar_len,
  input  logic [2:0]           ar_size,
  input  logic [1:0]           ar_burst,
  // read data
  output logic                 r_valid,
  input  logic                 r_ready,
  output logic [63:0]          r_data,
  output logic [1:0]           r_resp,
  output logic                 r_last,
  output logic [`NPC_ID_W-1:0] r_id
);

  npc_axi_pkg::axi_aw_t aw;
  npc_axi_pkg::axi_aw_t ar;
  npc_axi_pkg::axi_w_t  w;
  npc_axi_pkg::axi_b_t  b;
  npc_axi_pkg::axi_r_t  r;

  logic                                     req_valid;
  npc_axi_pkg::bank_req_t                   req;
  npc_axi_pkg::bank_rsp_t [`NPC_BANKS-1:0]  bank_rsp;
  npc_axi_pkg::room_t                       merge_room;

  // size and burst ride along in the structs, every burst is INCR of 8 bytes
  assign aw = '{addr: aw_addr, id: aw_id, len: aw_len, size: aw_size, burst: aw_burst};
  assign ar = '{addr: ar_addr, id: ar_id, len: ar_len, size: ar_size, burst: ar_burst};
  assign w  = '{data: w_data, strb: w_strb, last: w_last};

  assign b_resp = b.resp;
  assign b_id   = b.id;
  assign r_data = r.data;
  assign r_resp = r.resp;
  assign r_last = r.last;
  assign r_id   = r.id;

  npc_burst_ctrl u_ctrl (
    .clock      (clock),
    .rst_n      (rst_n),
    .aw_valid   (aw_valid),
    .aw         (aw),
    .aw_ready   (aw_ready),
    .w_valid    (w_valid),
    .w          (w),
    .w_ready    (w_ready),
    .b_valid    (b_valid),
    .b          (b),
    .b_ready    (b_ready),
    .ar_valid   (ar_valid),
    .ar         (ar),
    .ar_ready   (ar_ready),
    .req_valid  (req_valid),
    .req        (req),
    .merge_room (merge_room)
  );

  for (genvar g = 0; g < `NPC_BANKS; g++) begin : g_bank
    npc_ram_bank #(.BANK_ID(g)) u_bank (
      .clock     (clock),
      .rst_n     (rst_n),
      .req_valid (req_valid),
      .req       (req),
      .rsp       (bank_rsp[g])
    );
  end

  npc_rdata_merge u_merge (
    .clock      (clock),
    .rst_n      (rst_n),
    .req_valid  (req_valid),
    .req        (req),
    .rsp        (bank_rsp),
    .r_valid    (r_valid),
    .r          (r),
    .r_ready    (r_ready),
    .merge_room (merge_room)
  );

endmodule

`default_nettype wire

//--- verif/npc_mem_props.sv
`default_nettype none
`include "npc_consts.svh"

module npc_mem_props (
  input logic                 clock,
  input logic                 rst_n,
  input logic                 w_valid,
  input logic                 w_ready,
  input logic                 w_last,
  input logic                 b_valid,
  input logic                 b_ready,
  input logic [1:0]           b_resp,
  input logic [`NPC_ID_W-1:0] b_id,
  input logic                 r_valid,
  input logic                 r_ready,
  input logic [63:0]          r_data,
  input logic [1:0]           r_resp,
  input logic                 r_last,
  input logic [`NPC_ID_W-1:0] r_id
);

  // a stalled read beat keeps its payload
  a_r_hold: assert property (@(posedge clock) disable iff (!rst_n)
    r_valid && !r_ready |=> r_valid && $stable({r_data, r_id, r_resp, r_last}))
    else $error("read beat dropped or changed before r_ready");

  a_b_hold: assert property (@(posedge clock) disable iff (!rst_n)
    b_valid && !b_ready |=> b_valid && $stable({b_id, b_resp}))
    else $error("write response dropped or changed before b_ready");

  // response in the cycle after the last write beat
  a_b_after_last: assert property (@(posedge clock) disable iff (!rst_n)
    w_valid && w_ready && w_last |=> b_valid && !w_ready)
    else $error("no write response after the last write beat or w_ready still high");

endmodule

bind npc_mem_top npc_mem_props u_props (
  .clock   (clock),
  .rst_n   (rst_n),
  .w_valid (w_valid),
  .w_ready (w_ready),
  .w_last  (w_last),
  .b_valid (b_valid),
  .b_ready (b_ready),
  .b_resp  (b_resp),
  .b_id    (b_id),
  .r_valid (r_valid),
  .r_ready (r_ready),
  .r_data  (r_data),
  .r_resp  (r_resp),
  .r_last  (r_last),
  .r_id    (r_id)
);

`default_nettype wire

//--- verif/npc_mem_tb.sv
`default_nettype none
`include "npc_consts.svh"

module npc_mem_tb;

  localparam int N_FILL     = 128;  // 8-beat bursts covering all 1024 words
  localparam int N_TXN      = 300;
  localparam int MAX_CYCLES = (N_FILL + N_TXN) * 40 + 3000;

  logic clock;
  logic rst_n;
  logic aw_valid, aw_ready, w_valid, w_ready, b_valid, b_ready;
  logic ar_valid, ar_ready, r_valid, r_ready;
  logic [31:0] aw_addr, ar_addr;
  logic [`NPC_ID_W-1:0] aw_id, ar_id, b_id, r_id;
  logic [7:0] aw_len, ar_len, w_strb;
  logic [2:0] aw_size, ar_size;
  logic [1:0] aw_burst, ar_burst, b_resp, r_resp;
  logic [63:0] w_data, r_data;
  logic w_last, r_last;

  logic [63:0] model [1024];  // indexed by addr[12:3]
  int cycles;

  npc_mem_top UUT (
    .clock (clock), .rst_n (rst_n),
    .aw_valid (aw_valid), .aw_ready (aw_ready), .aw_addr (aw_addr), .aw_id (aw_id),
    .aw_len (aw_len), .aw_size (aw_size), .aw_burst (aw_burst),
    .w_valid (w_valid), .w_ready (w_ready), .w_data (w_data), .w_strb (w_strb),
    .w_last (w_last),
    .b_valid (b_valid), .b_ready (b_ready), .b_resp (b_resp), .b_id (b_id),
    .ar_valid (ar_valid), .ar_ready (ar_ready), .ar_addr (ar_addr), .ar_id (ar_id),
    .ar_len (ar_len), .ar_size (ar_size), .ar_burst (ar_burst),
    .r_valid (r_valid), .r_ready (r_ready), .r_data (r_data), .r_resp (r_resp),
    .r_last (r_last), .r_id (r_id)
  );

  always #2 clock = ~clock;

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("SOME TESTS FAILED");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("FAILED at %0t: %s is %h, expected %h", $time, name, got, exp));
    end
  endtask

  always @(posedge clock) begin
    cycles <= cycles + 1;
    if (cycles == MAX_CYCLES) begin
      abort_run($sformatf("run did not finish within %0d clock cycles", MAX_CYCLES));
    end
  end

  function automatic logic [63:0] fill_word(input int idx);
    logic [12:0] a;
    a = 13'(idx << 3);
    return {~{19'd0, a}, {19'd0, a} ^ 32'h9e37_79b9};
  endfunction

  function automatic logic [63:0] merge_bytes(input logic [63:0] old, input logic [63:0] data,
                                              input logic [7:0] strb);
    logic [63:0] res;
    res = old;
    for (int i = 0; i < 8; i++) begin
      if (strb[i]) res[i*8 +: 8] = data[i*8 +: 8];
    end
    return res;
  endfunction

  // ends on the handshake edge
  task automatic send_aw(input logic [31:0] addr, input logic [`NPC_ID_W-1:0] id, input int len);
    @(posedge clock);
    aw_valid <= 1'b1;
    aw_addr  <= addr;
    aw_id    <= id;
    aw_len   <= 8'(len);
    @(negedge clock);
    while (!aw_ready) @(negedge clock);
    @(posedge clock);
    aw_valid <= 1'b0;
  endtask

  task automatic send_ar(input logic [31:0] addr, input logic [`NPC_ID_W-1:0] id, input int len);
    @(posedge clock);
    ar_valid <= 1'b1;
    ar_addr  <= addr;
    ar_id    <= id;
    ar_len   <= 8'(len);
    @(negedge clock);
    while (!ar_ready) @(negedge clock);
    @(posedge clock);
    ar_valid <= 1'b0;
  endtask

  task automatic send_w(input int base, input int len, input bit fill);
    int          beat;
    int          idx;
    bit          presenting;
    logic [63:0] data;
    logic [7:0]  strb;
    beat = 0;
    presenting = 0;
    while (beat <= len) begin
      idx = (base + beat) & 1023;
      if (!presenting) begin
        if ($urandom_range(3) != 0) begin
          data = fill ? fill_word(idx) : {$urandom, $urandom};
          strb = (fill || $urandom_range(2) == 0) ? 8'hff : 8'($urandom);
          w_valid <= 1'b1;
          w_data  <= data;
          w_strb  <= strb;
          w_last  <= (beat == len);
          presenting = 1;
        end else begin
          w_valid <= 1'b0;  // gap
        end
      end
      @(negedge clock);
      if (presenting && w_ready) begin
        model[idx] = merge_bytes(model[idx], data, strb);
        beat++;
        presenting = 0;
      end
      @(posedge clock);
    end
    w_valid <= 1'b0;
    w_last  <= 1'b0;
  endtask

  task automatic take_b(input logic [`NPC_ID_W-1:0] id);
    bit got;
    got = 0;
    while (!got) begin
      b_ready <= ($urandom_range(2) != 0);
      @(negedge clock);
      if (b_valid && b_ready) begin
        check_value("b_id", 64'(b_id), 64'(id));
        check_value("b_resp", 64'(b_resp), 64'd0);
        got = 1;
      end
      @(posedge clock);
    end
    b_ready <= 1'b0;
    @(negedge clock);
    check_value("b_valid after response", 64'(b_valid), 64'd0);
  endtask

  task automatic take_r(input int base, input int len, input logic [`NPC_ID_W-1:0] id);
    int beat;
    beat = 0;
    while (beat <= len) begin
      r_ready <= ($urandom_range(2) != 0);
      @(negedge clock);
      if (r_valid && r_ready) begin
        check_value("r_data", r_data, model[(base + beat) & 1023]);
        check_value("r_id", 64'(r_id), 64'(id));
        check_value("r_resp", 64'(r_resp), 64'd0);
        check_value("r_last", 64'(r_last), 64'(beat == len));
        beat++;
      end
      @(posedge clock);
    end
    r_ready <= 1'b0;
    @(negedge clock);
    check_value("r_valid after last beat", 64'(r_valid), 64'd0);
  endtask

  initial begin
    logic [31:0]          addr;
    logic [`NPC_ID_W-1:0] id;
    int                   len;
    clock    = 1'b0;
    rst_n    = 1'b0;
    cycles   = 0;
    aw_valid = 1'b0;
    aw_addr  = '0;
    aw_id    = '0;
    aw_len   = '0;
    aw_size  = 3'd3;
    aw_burst = 2'b01;
    w_valid  = 1'b0;
    w_data   = '0;
    w_strb   = '0;
    w_last   = 1'b0;
    b_ready  = 1'b0;
    ar_valid = 1'b0;
    ar_addr  = '0;
    ar_id    = '0;
    ar_len   = '0;
    ar_size  = 3'd3;
    ar_burst = 2'b01;
    r_ready  = 1'b0;
    void'($urandom(32'h48ca_20fb));

    // outputs quiet during reset
    @(negedge clock);
    check_value("aw_ready in reset", 64'(aw_ready), 64'd0);
    check_value("w_ready in reset", 64'(w_ready), 64'd0);
    check_value("ar_ready in reset", 64'(ar_ready), 64'd0);
    check_value("b_valid in reset", 64'(b_valid), 64'd0);
    check_value("r_valid in reset", 64'(r_valid), 64'd0);
    @(posedge clock);
    rst_n <= 1'b1;
    @(negedge clock);
    @(negedge clock);
    check_value("aw_ready after reset", 64'(aw_ready), 64'd1);

    for (int i = 0; i < N_FILL; i++) begin
      send_aw(32'(i * 64), 4'(i), 7);
      send_w(i * 8, 7, 1'b1);
      take_b(4'(i));
    end

    for (int n = 0; n < N_TXN; n++) begin
      id = 4'($urandom);
      if ($urandom_range(3) == 0) begin
        // starts in the top four words so the burst wraps to 0
        addr = ($urandom & 32'hffff_e000) | (32'h1fe0 + (32'($urandom_range(3)) << 3));
        len  = 4 + $urandom_range(3);
      end else begin
        addr = $urandom & 32'hffff_fff8;
        len  = $urandom_range(7);
      end
      if ($urandom_range(4) < 3) begin
        send_aw(addr, id, len);
        send_w(int'(addr[12:3]), len, 1'b0);
        take_b(id);
      end else begin
        send_ar(addr, id, len);
        take_r(int'(addr[12:3]), len, id);
      end
    end

    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- project.f
+incdir+verilog
verilog/npc_axi_pkg.sv
verilog/npc_ram_bank.sv
verilog/npc_burst_ctrl.sv
verilog/npc_rdata_merge.sv
verilog/npc_mem_top.sv
verif/npc_mem_props.sv
verif/npc_mem_tb.sv

//--- run.sh
#!/bin/sh
# build and run the memory testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module npc_mem_tb \
  -f project.f \
  --Mdir obj_dir \
  -o npc_mem_sim

./obj_dir/npc_mem_sim
